// ==== tests/enc_buf_vectors.txt ====
# one command per line, values in hex, n, stall, mode and delay in decimal
# W row sel data n stall / C tag / S status {empty_any,empty_all,full_any,full_all}
# B data tag last n (data +01010101 per row, last on the final beat) / P mode delay / D
P 1 0
S c
# frame in bank 0, full rows
W 0 f 03020100 16 0
C a1
S a
B 03020100 a1 1 16
D
S c
# bank 1, full rows then partial lanes over them
W 0 f 13121110 16 0
W 2 1 000000ee 1 0
W 5 a dd00cc00 1 0
W f c bbaa0000 1 0
C b2
B 13121110 b2 0 2
B 151413ee b2 0 1
B 16151413 b2 0 2
B dd17cc15 b2 0 1
B 19181716 b2 0 9
B bbaa201f b2 1 1
D
# ready low, both banks committed
P 0 0
W 0 f 23222120 16 0
C c3
W 0 f 33323130 8 0
C d4
S 3
B 23222120 c3 1 16
B 33323130 d4 0 8
B 1b1a1918 d4 0 7
B bbaa201f d4 1 1
# stalls until ready returns and bank 0 drains
P 1 12
W 3 f 77665544 1 12
# random ready, bank 0 keeps its old rows around row 3
P 2 0
C e5
B 23222120 e5 0 3
B 77665544 e5 0 1
B 27262524 e5 1 12
W 0 f 43424140 16 0
C f6
B 43424140 f6 1 16
D
S c

// ==== enc_buf_top.f ====
common/enc_buf_pkg.sv
common/wb_pkg.sv
design/lane_ram.sv
design/bank_ctrl.sv
wb_frontend/wb_frame_writer.sv
reader/frame_reader.sv
design/enc_buf_top.sv
tests/enc_buf_tb.sv

// ==== Makefile ====
# frame buffer simulation with Verilator, the exit status of run carries pass or fail

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module enc_buf_tb -f enc_buf_top.f

run: build
	./obj_dir/Venc_buf_tb

lint:
	verilator --lint-only --timing --assert -Wall \
		--top-module enc_buf_top -f enc_buf_top.f

clean:
	rm -rf obj_dir

// ==== tests/enc_buf_tb.sv ====
// testbench of the frame buffer, replays the command vectors on the wishbone port and checks beats
`timescale 1ns/1ps

module enc_buf_tb;

  localparam int          LINE_CYCLES = 40;            // timeout budget per vector line
  localparam int          ACK_MAX     = 400;           // longest wait for one ack
  localparam logic [31:0] ROW_STEP    = 32'h0101_0101; // each lane +1 per row in a run
  localparam wb_pkg::wb_adr_t CTRL_ADR = wb_pkg::wb_adr_t'(1 << wb_pkg::REGION_BIT);

  logic                      iwclk;
  logic                      rst;
  wb_pkg::wb_req_t           wb_req;
  wb_pkg::wb_rsp_t           wb_rsp;
  enc_buf_pkg::beat_t        beat;
  logic                      beat_valid;
  logic                      beat_ready;

  enc_buf_pkg::beat_t        exp_q[$];    // beats still to come, in stream order
  enc_buf_pkg::beat_t        got_q[$];    // accepted beats not yet matched
  string                     lines[$];    // command lines of the vector file
  int                        ready_mode;  // 0 low, 1 high, 2 random
  int                        pend_mode;
  int                        pend_cnt;    // edges until pend_mode applies
  int                        cycles;
  int                        cycle_limit;

  enc_buf_top dut (
    .iwclk      (iwclk),
    .rst        (rst),
    .wb_req     (wb_req),
    .wb_rsp     (wb_rsp),
    .beat       (beat),
    .beat_valid (beat_valid),
    .beat_ready (beat_ready)
  );

  always #50 iwclk = ~iwclk; // 100 ns period

  // ----------------------------------------
  // failure reporting and compares
  // ----------------------------------------
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_beat(input enc_buf_pkg::beat_t got, input enc_buf_pkg::beat_t exp);
    if (got.data !== exp.data) report_mismatch("beat.data", got.data, exp.data);
    if (got.tag !== exp.tag) report_mismatch("beat.tag", 32'(got.tag), 32'(exp.tag));
    if (got.last !== exp.last) report_mismatch("beat.last", 32'(got.last), 32'(exp.last));
  endtask

  task automatic check_status(input enc_buf_pkg::bank_status_t got,
                              input enc_buf_pkg::bank_status_t exp);
    if (got !== exp) report_mismatch("status", 32'(got), 32'(exp));
  endtask

  // stall = cycles that must pass with no ack, 0 when none expected
  task automatic check_ack(input logic acked, input int waited, input int stall,
                           input wb_pkg::wb_adr_t adr);
    if (!acked) begin
      fail_run($sformatf("access to address %h got no ack within %0d cycles", adr, ACK_MAX));
    end
    if (stall > 0 && waited <= stall) begin
      fail_run($sformatf("access to address %h was acked after %0d cycles while it should stall",
                         adr, waited));
    end
  endtask

  // ----------------------------------------
  // wishbone master, called on a falling edge
  // ----------------------------------------
  task automatic bus_cycle(input logic we, input wb_pkg::wb_adr_t adr, input wb_pkg::wb_dat_t dat,
                           input wb_pkg::wb_sel_t sel, input int stall,
                           output wb_pkg::wb_dat_t rdat);
    int   waited;
    logic acked;
    waited     = 0;
    acked      = 1'b0;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = dat;
    wb_req.sel = sel;
    while (!acked && waited < ACK_MAX) begin
      @(negedge iwclk);
      waited++;
      acked = wb_rsp.ack;
    end
    check_ack(acked, waited, stall, adr);
    rdat = wb_rsp.dat;
    @(negedge iwclk);  // hold over the edge that samples ack
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
  endtask

  task automatic row_write(input enc_buf_pkg::row_t row, input wb_pkg::wb_sel_t sel,
                           input logic [31:0] data, input int n, input int stall);
    wb_pkg::wb_wdat_u wdat;
    wb_pkg::wb_dat_t  rdat;
    for (int k = 0; k < n; k++) begin
      wdat = data + ROW_STEP * k;  // lanes view, lane 0 low byte
      bus_cycle(1'b1, wb_pkg::wb_adr_t'(enc_buf_pkg::row_t'(int'(row) + k)), wdat, sel,
                (k == 0) ? stall : 0, rdat);
    end
  endtask

  task automatic commit_frame(input enc_buf_pkg::tag_t tag);
    wb_pkg::wb_wdat_u wdat;
    wb_pkg::wb_dat_t  rdat;
    wdat.ctrl.rsvd = '0;
    wdat.ctrl.tag  = tag;
    bus_cycle(1'b1, CTRL_ADR, wdat, 4'hf, 0, rdat);
  endtask

  task automatic status_read(input enc_buf_pkg::bank_status_t exp);
    wb_pkg::wb_dat_t rdat;
    bus_cycle(1'b0, CTRL_ADR, '0, 4'hf, 0, rdat);
    check_status(enc_buf_pkg::bank_status_t'(rdat[3:0]), exp);
    if (rdat[31:4] !== '0) report_mismatch("wb_rsp.dat[31:4]", 32'(rdat[31:4]), 32'h0);
  endtask

  // a run of n beats, last only on the final one when asked
  task automatic queue_beats(input logic [31:0] data, input enc_buf_pkg::tag_t tag,
                             input logic last, input int n);
    enc_buf_pkg::beat_t b;
    for (int k = 0; k < n; k++) begin
      b.data = data + ROW_STEP * k;
      b.tag  = tag;
      b.last = last && (k == n - 1);
      exp_q.push_back(b);
    end
  endtask

  // ----------------------------------------
  // vector interpreter
  // ----------------------------------------
  task automatic run_line(input string line);
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    int          n;
    int          stall;
    int          cnt;
    cnt = 0;
    case (line.getc(0))
      "W": cnt = $sscanf(line, "W %h %h %h %d %d", f1, f2, f3, n, stall) - 5;
      "C", "S": cnt = $sscanf(line.substr(1, line.len() - 1), " %h", f1) - 1;
      "B": cnt = $sscanf(line, "B %h %h %h %d", f1, f2, f3, n) - 4;
      "P": cnt = $sscanf(line, "P %d %d", n, stall) - 2;
      "D": cnt = 0;
      default: fail_run($sformatf("unknown command in vector line: %s", line));
    endcase
    if (cnt != 0) fail_run($sformatf("malformed vector line: %s", line));
    case (line.getc(0))
      "W": row_write(enc_buf_pkg::row_t'(f1), wb_pkg::wb_sel_t'(f2), f3, n, stall);
      "C": commit_frame(enc_buf_pkg::tag_t'(f1));
      "S": status_read(enc_buf_pkg::bank_status_t'(f1));
      "B": queue_beats(f1, enc_buf_pkg::tag_t'(f2), f3[0], n);
      "P": begin
        pend_mode = n;
        pend_cnt  = stall + 1;  // applied on a rising edge
      end
      default: begin
        while (exp_q.size() != 0) @(posedge iwclk);
        @(negedge iwclk);
      end
    endcase
  endtask

  // ----------------------------------------
  // ready driver and beat monitor
  // ----------------------------------------
  always @(negedge iwclk) begin
    if (rst) begin
      beat_ready = 1'b0;
    end else begin
      case (ready_mode)
        0:       beat_ready = 1'b0;
        1:       beat_ready = 1'b1;
        default: beat_ready = 1'($urandom % 2);
      endcase
      // transfer happens on the coming rising edge, beat holds until then
      if (beat_valid && beat_ready) begin
        got_q.push_back(beat);
      end
      // a frame may stream out before its B lines are read
      while (got_q.size() != 0 && exp_q.size() != 0) begin
        check_beat(got_q.pop_front(), exp_q.pop_front());
      end
    end
  end

  // delayed ready mode change
  always @(posedge iwclk) begin
    if (pend_cnt > 0) begin
      pend_cnt = pend_cnt - 1;
      if (pend_cnt == 0) ready_mode = pend_mode;
    end
  end

  // timeout
  always @(posedge iwclk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      fail_run($sformatf("run did not finish within %0d cycles", cycle_limit));
    end
  end

  initial begin
    int    fd;
    string line;
    iwclk       = 1'b0;
    rst         = 1'b1;
    wb_req      = '0;
    beat_ready  = 1'b0;
    ready_mode  = 1;
    pend_mode   = 1;
    pend_cnt    = 0;
    cycles      = 0;
    cycle_limit = 0;
    void'($urandom(32'h4e4f_3069));

    fd = $fopen("tests/enc_buf_vectors.txt", "r");
    if (fd == 0) fail_run("cannot open tests/enc_buf_vectors.txt");
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) > 0 && line.len() > 1 && line.getc(0) != "#") begin
        lines.push_back(line);
      end
    end
    $fclose(fd);
    cycle_limit = LINE_CYCLES * lines.size();

    repeat (5) @(posedge iwclk);
    @(negedge iwclk);
    rst = 1'b0;

    foreach (lines[i]) run_line(lines[i]);
    repeat (4) @(negedge iwclk);  // room for a stray beat to show up

    if (exp_q.size() == 0 && got_q.size() == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      fail_run($sformatf("%0d expected beats never arrived, %0d beats were not expected",
                         exp_q.size(), got_q.size()));
    end
  end

endmodule

// ==== design/enc_buf_top.sv ====
// frame buffer top, wishbone host writes rows and commits, the beat stream drains banks
`timescale 1ns/1ps

module enc_buf_top (
  input  logic                      iwclk,
  input  logic                      rst,
  input  wb_pkg::wb_req_t           wb_req,
  output wb_pkg::wb_rsp_t           wb_rsp,
  output enc_buf_pkg::beat_t        beat,
  output logic                      beat_valid,
  input  logic                      beat_ready
);

  // ----------------------------------------
  // writer side
  // ----------------------------------------
  logic [enc_buf_pkg::LANE_N-1:0] lane_we;
  enc_buf_pkg::row_t              wr_row;
  enc_buf_pkg::lane_bytes_t       wr_bytes;
  logic                           commit;
  enc_buf_pkg::tag_t              commit_tag;
  enc_buf_pkg::bank_status_t      status;
  enc_buf_pkg::bank_t             wr_bank;
  enc_buf_pkg::buf_addr_t         waddr;

  // reader side
  enc_buf_pkg::bank_t             rd_bank;
  enc_buf_pkg::tag_t              rd_tag;
  logic                           re;
  enc_buf_pkg::row_t              rd_row;
  enc_buf_pkg::lane_bytes_t       lane_rdat;
  logic                           bank_release;
  enc_buf_pkg::buf_addr_t         raddr;

  assign waddr = '{bank: wr_bank, row: wr_row};
  assign raddr = '{bank: rd_bank, row: rd_row};

  wb_frame_writer u_writer (
    .iwclk      (iwclk),
    .rst        (rst),
    .wb_req     (wb_req),
    .wb_rsp     (wb_rsp),
    .lane_we    (lane_we),
    .wr_row     (wr_row),
    .wr_bytes   (wr_bytes),
    .commit     (commit),
    .commit_tag (commit_tag),
    .status     (status)
  );

  bank_ctrl u_bank_ctrl (
    .iwclk        (iwclk),
    .rst          (rst),
    .commit       (commit),
    .commit_tag   (commit_tag),
    .bank_release (bank_release),
    .wr_bank      (wr_bank),
    .rd_bank      (rd_bank),
    .rd_tag       (rd_tag),
    .status       (status)
  );

  // ----------------------------------------
  // one memory per byte lane
  // ----------------------------------------
  for (genvar g = 0; g < enc_buf_pkg::LANE_N; g++) begin : g_lane
    lane_ram u_ram (
      .iwclk (iwclk),
      .we    (lane_we[g]),    // own sel bit
      .waddr (waddr),
      .wdat  (wr_bytes[g]),
      .re    (re),
      .raddr (raddr),
      .rdat  (lane_rdat[g])   // lands in byte g of the beat
    );
  end

  frame_reader u_reader (
    .iwclk        (iwclk),
    .rst          (rst),
    .rd_bank      (rd_bank),
    .rd_tag       (rd_tag),
    .empty_all    (status.empty_all),
    .re           (re),
    .rd_row       (rd_row),
    .lane_rdat    (lane_rdat),
    .beat         (beat),
    .beat_valid   (beat_valid),
    .beat_ready   (beat_ready),
    .bank_release (bank_release)
  );

endmodule

// ==== reader/frame_reader.sv ====
// frame reader, streams a committed bank row by row as beats and hands the bank back
`timescale 1ns/1ps

module frame_reader (
  input  logic                     iwclk,
  input  logic                     rst,
  input  enc_buf_pkg::bank_t       rd_bank,
  input  enc_buf_pkg::tag_t        rd_tag,
  input  logic                     empty_all,
  output logic                     re,
  output enc_buf_pkg::row_t        rd_row,
  input  enc_buf_pkg::lane_bytes_t lane_rdat,
  output enc_buf_pkg::beat_t       beat,
  output logic                     beat_valid,
  input  logic                     beat_ready,
  output logic                     bank_release
);

  enc_buf_pkg::row_t row_q;   // next row to fetch
  logic              done_q;  // all rows fetched, waiting for release
  logic              valid_q; // beat held at ram output
  logic              last_q;  // held beat is row 15
  logic              pop;     // held beat leaves this cycle
  logic              last_row;

  // ----------------------------------------
  // fetch
  // ----------------------------------------
  assign pop      = valid_q && beat_ready;
  assign last_row = (row_q == enc_buf_pkg::ROW_N - 1);

  // fetch when the slot is free or emptied this cycle
  assign re     = !empty_all && !done_q && (!valid_q || beat_ready);
  assign rd_row = row_q;

  always_ff @(posedge iwclk) begin
    if (rst) begin
      row_q  <= '0;
      done_q <= 1'b0;
    end else begin
      if (re) begin
        row_q <= row_q + 1'b1; // wraps to row 0 for the next bank
        if (last_row) begin
          done_q <= 1'b1;
        end
      end else if (bank_release) begin
        done_q <= 1'b0;        // next bank no earlier than next cycle
      end
    end
  end

  // ----------------------------------------
  // beat slot
  // ----------------------------------------
  always_ff @(posedge iwclk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (re) begin
      valid_q <= 1'b1;  // data shows up on the ram register
    end else if (pop) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge iwclk) begin
    if (re) begin
      last_q <= last_row;
    end
  end

  // ram output holds while re is low, so the beat holds too
  assign beat.data  = lane_rdat;
  assign beat.tag   = rd_tag;
  assign beat.last  = last_q;
  assign beat_valid = valid_q;

  assign bank_release = pop && last_q; // pulse as the last beat leaves

  // ----------------------------------------
  // checks
  // ----------------------------------------
  a_beat_stable : assert property (
    @(posedge iwclk) disable iff (rst)
    (valid_q && !beat_ready) |=> (valid_q && $stable(beat))
  );

  // bank control must not move the read bank under a running frame
  a_bank_steady : assert property (
    @(posedge iwclk) disable iff (rst)
    ((re || valid_q) && !bank_release) |=> $stable(rd_bank)
  );

endmodule

// ==== wb_frontend/wb_frame_writer.sv ====
// wishbone classic slave of the frame buffer, turns host cycles into row writes and commits
`timescale 1ns/1ps

module wb_frame_writer (
  input  logic                           iwclk,
  input  logic                           rst,
  input  wb_pkg::wb_req_t                wb_req,
  output wb_pkg::wb_rsp_t                wb_rsp,
  output logic [enc_buf_pkg::LANE_N-1:0] lane_we,
  output enc_buf_pkg::row_t              wr_row,
  output enc_buf_pkg::lane_bytes_t       wr_bytes,
  output logic                           commit,
  output enc_buf_pkg::tag_t              commit_tag,
  input  enc_buf_pkg::bank_status_t      status
);

  wb_pkg::wb_wdat_u wdat;        // write word, two views
  logic             region_ctrl; // control region selected
  logic             req_new;     // cycle seen, not yet acked
  logic             wr_ok;       // access may proceed now
  logic             accept;      // ack rises on this edge
  logic             ack_q;
  wb_pkg::wb_dat_t  rdat_q;

  // ----------------------------------------
  // decode
  // ----------------------------------------
  assign wdat        = wb_req.dat;
  assign region_ctrl = wb_req.adr[wb_pkg::REGION_BIT];

  // ack_q high means this request was served, so no second pulse
  assign req_new = wb_req.cyc && wb_req.stb && !ack_q;

  // writes stall while both banks wait for the reader
  assign wr_ok  = !wb_req.we || !status.full_all;
  assign accept = req_new && wr_ok;

  // row write, lanes picked by sel
  assign lane_we  = (accept && wb_req.we && !region_ctrl) ? wb_req.sel : '0;
  assign wr_row   = wb_req.adr[enc_buf_pkg::ROW_W-1:0];
  assign wr_bytes = wdat.lanes;

  // commit of the current write bank
  assign commit     = accept && wb_req.we && region_ctrl;
  assign commit_tag = wdat.ctrl.tag;

  // ----------------------------------------
  // response
  // ----------------------------------------
  always_ff @(posedge iwclk) begin
    if (rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= accept; // single cycle, master drops stb after it
    end
  end

  // read data, status in the low bits, data region reads as zero
  always_ff @(posedge iwclk) begin
    if (accept) begin
      if (!wb_req.we && region_ctrl) begin
        rdat_q <= wb_pkg::wb_dat_t'(status);
      end else begin
        rdat_q <= '0;
      end
    end
  end

  assign wb_rsp = '{ack: ack_q, dat: rdat_q};

  // ----------------------------------------
  // checks
  // ----------------------------------------
  // ack only inside a live cycle, master must hold until it sees it
  a_ack_in_cycle : assert property (
    @(posedge iwclk) disable iff (rst)
    ack_q |-> (wb_req.cyc && wb_req.stb)
  );

  // a stalled request stays on the bus unchanged until it is acked
  a_req_held : assert property (
    @(posedge iwclk) disable iff (rst)
    (wb_req.cyc && wb_req.stb && !ack_q) |=>
      (wb_req.cyc && wb_req.stb && $stable(wb_req.we) && $stable(wb_req.adr))
  );

endmodule

// ==== design/bank_ctrl.sv ====
// ping-pong bank control of the frame buffer, tracks write and read banks and frame tags
`timescale 1ns/1ps

module bank_ctrl (
  input  logic                      iwclk,
  input  logic                      rst,
  input  logic                      commit,
  input  enc_buf_pkg::tag_t         commit_tag,
  input  logic                      bank_release,
  output enc_buf_pkg::bank_t        wr_bank,
  output enc_buf_pkg::bank_t        rd_bank,
  output enc_buf_pkg::tag_t         rd_tag,
  output enc_buf_pkg::bank_status_t status
);

  enc_buf_pkg::bank_t             wr_ptr;
  enc_buf_pkg::bank_t             rd_ptr;
  logic [enc_buf_pkg::BANK_W:0]   full_cnt;  // 0 .. BANK_N committed banks
  enc_buf_pkg::tag_t              tag_q [enc_buf_pkg::BANK_N];

  // ----------------------------------------
  // pointers and count
  // ----------------------------------------
  always_ff @(posedge iwclk) begin
    if (rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      full_cnt <= '0;
    end else begin
      if (commit) begin
        wr_ptr <= wr_ptr + 1'b1; // wraps over the banks
      end
      if (bank_release) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // commit and release together leave the count alone
      case ({commit, bank_release})
        2'b10:   full_cnt <= full_cnt + 1'b1;
        2'b01:   full_cnt <= full_cnt - 1'b1;
        default: full_cnt <= full_cnt;
      endcase
    end
  end

  // tag of each bank, written with its commit
  always_ff @(posedge iwclk) begin
    if (commit) begin
      tag_q[wr_ptr] <= commit_tag;
    end
  end

  assign wr_bank = wr_ptr;
  assign rd_bank = rd_ptr;
  assign rd_tag  = tag_q[rd_ptr]; // stable for the whole frame

  // ----------------------------------------
  // flags
  // ----------------------------------------
  assign status.empty_any = (full_cnt != enc_buf_pkg::BANK_N); // a bank is free
  assign status.empty_all = (full_cnt == '0);
  assign status.full_any  = (full_cnt != '0);                  // reader has work
  assign status.full_all  = (full_cnt == enc_buf_pkg::BANK_N);

  // reader may only hand back a bank that was committed
  a_no_release_empty : assert property (
    @(posedge iwclk) disable iff (rst)
    bank_release |-> !status.empty_all
  );

  // a commit with both banks full would overrun the reader
  a_no_commit_full : assert property (
    @(posedge iwclk) disable iff (rst)
    commit |-> !status.full_all
  );

endmodule

// ==== design/lane_ram.sv ====
// one byte lane of frame buffer memory, both banks, registered read port
`timescale 1ns/1ps

module lane_ram (
  input  logic                   iwclk,
  input  logic                   we,
  input  enc_buf_pkg::buf_addr_t waddr,
  input  enc_buf_pkg::lane_t     wdat,
  input  logic                   re,
  input  enc_buf_pkg::buf_addr_t raddr,
  output enc_buf_pkg::lane_t     rdat
);

  // bank in the top address bit
  enc_buf_pkg::lane_t mem [enc_buf_pkg::MEM_D];

  // ----------------------------------------
  // write port
  // ----------------------------------------
  always_ff @(posedge iwclk) begin
    if (we) begin
      mem[waddr] <= wdat;
    end
  end

  // ----------------------------------------
  // read port, one cycle, holds when idle
  // ----------------------------------------
  always_ff @(posedge iwclk) begin
    if (re) begin
      rdat <= mem[raddr];
    end
  end

endmodule

// ==== common/wb_pkg.sv ====
// wishbone classic port types and address map of the frame buffer host interface
package wb_pkg;

  // ----------------------------------------
  // bus widths
  // ----------------------------------------
  localparam int WB_ADR_W   = 8;
  localparam int WB_DAT_W   = 32;
  localparam int WB_SEL_W   = WB_DAT_W / 8; // one sel bit per byte lane
  localparam int REGION_BIT = 7;            // 0 data rows, 1 control

  typedef logic [WB_ADR_W-1:0] wb_adr_t;
  typedef logic [WB_DAT_W-1:0] wb_dat_t;
  typedef logic [WB_SEL_W-1:0] wb_sel_t;

  typedef struct packed {
    logic    cyc;
    logic    stb;
    logic    we;
    wb_adr_t adr;
    wb_dat_t dat;
    wb_sel_t sel;
  } wb_req_t;

  typedef struct packed {
    logic    ack;
    wb_dat_t dat;
  } wb_rsp_t;

  // control word, tag in the low byte
  typedef struct packed {
    logic [WB_DAT_W-enc_buf_pkg::TAG_W-1:0] rsvd;
    enc_buf_pkg::tag_t                      tag;
  } wb_ctrl_t;

  // same write word, seen as row bytes or as a commit word
  typedef union packed {
    enc_buf_pkg::lane_bytes_t lanes;
    wb_ctrl_t                 ctrl;
  } wb_wdat_u;

endpackage

// ==== common/enc_buf_pkg.sv ====
// buffer geometry and stream types, shared by the frame buffer RTL and its testbench
package enc_buf_pkg;

  // ----------------------------------------
  // geometry
  // ----------------------------------------
  localparam int LANE_N = 4;              // byte lanes per row
  localparam int LANE_W = 8;              // bits per lane
  localparam int ROW_W  = 4;              // 16 rows per frame
  localparam int BANK_W = 1;              // ping-pong, 2 banks
  localparam int TAG_W  = 8;

  localparam int ROW_N  = 2**ROW_W;
  localparam int BANK_N = 2**BANK_W;
  localparam int MEM_D  = BANK_N * ROW_N; // words per lane memory

  typedef logic [ROW_W-1:0]  row_t;
  typedef logic [BANK_W-1:0] bank_t;
  typedef logic [TAG_W-1:0]  tag_t;
  typedef logic [LANE_W-1:0] lane_t;

  typedef lane_t [LANE_N-1:0] lane_bytes_t; // lane 0 in the low byte

  // lane memory address, bank on top
  typedef struct packed {
    bank_t bank;
    row_t  row;
  } buf_addr_t;

  // one output beat = one full row
  typedef struct packed {
    logic [LANE_N*LANE_W-1:0] data;
    tag_t                     tag;
    logic                     last;  // set on row 15 only
  } beat_t;

  // occupancy flags, full_all sits in bit 0
  typedef struct packed {
    logic empty_any;
    logic empty_all;
    logic full_any;
    logic full_all;
  } bank_status_t;

endpackage
